// ==== ooo_pkg.sv ====
`default_nettype none

package ooo_pkg;

	////////////////////////////////
	// widths and basic words
	////////////////////////////////

	localparam int xlen = 32;

	typedef logic [4:0]      reg_idx_t;
	typedef logic [xlen-1:0] word_t;

	////////////////////////////////
	// alu operations
	////////////////////////////////

	typedef enum logic [3:0] {
		alu_add  = 4'd0,
		alu_sub  = 4'd1,
		alu_sll  = 4'd2,
		alu_slt  = 4'd3,
		alu_sltu = 4'd4,
		alu_xor  = 4'd5,
		alu_srl  = 4'd6,
		alu_sra  = 4'd7,
		alu_or   = 4'd8,
		alu_and  = 4'd9
	} alu_op_e;

	////////////////////////////////
	// instruction word
	////////////////////////////////

	// same 32 bits, r-type view for OP and i-type view for OP-IMM
	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			reg_idx_t   rs2;
			reg_idx_t   rs1;
			logic [2:0] funct3;
			reg_idx_t   rd;
			logic [6:0] opcode;
		} r;
		struct packed {
			logic [11:0] imm12;
			reg_idx_t    rs1;
			logic [2:0]  funct3;
			reg_idx_t    rd;
			logic [6:0]  opcode;
		} i;
	} inst_word_u;

	// the only two opcode groups the core accepts
	localparam logic [6:0] opcode_op     = 7'b0110011;
	localparam logic [6:0] opcode_op_imm = 7'b0010011;

endpackage

`default_nettype wire

// ==== issue_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_decode import ooo_pkg::*; (
	input  logic       inst_valid,
	input  inst_word_u inst,
	input  logic       rob_full,
	input  logic       rs_full,
	output logic       stall,
	output logic       issue,
	output alu_op_e    op,
	output reg_idx_t   rd,
	output reg_idx_t   rs1,
	output reg_idx_t   rs2,
	output logic       use_imm,
	output word_t      imm
);

	logic       known_op;
	logic [2:0] funct3;
	logic       alt_bit;

	// back-pressure: no room in either rob or station
	assign stall = rob_full | rs_full;

	always_comb begin
		known_op = 1'b0;
		use_imm  = 1'b0;
		// rd, rs1 and funct3 sit in the same bits in both views
		rd       = inst.r.rd;
		rs1      = inst.r.rs1;
		rs2      = '0;
		imm      = '0;
		funct3   = inst.r.funct3;
		alt_bit  = 1'b0;
		case (inst.r.opcode)
			opcode_op: begin
				known_op = 1'b1;
				rs2      = inst.r.rs2;
				// bit 30 picks sub / sra
				alt_bit  = inst.r.funct7[5];
			end
			opcode_op_imm: begin
				known_op = 1'b1;
				use_imm  = 1'b1;
				imm      = {{(xlen-12){inst.i.imm12[11]}}, inst.i.imm12};
				// addi has no subtract form, only srai uses bit 30
				alt_bit  = (inst.i.funct3 == 3'b101) & inst.i.imm12[10];
			end
			default: begin
				known_op = 1'b0;
			end
		endcase
	end

	// funct3 to operation
	always_comb begin
		case (funct3)
			3'b000:  op = alt_bit ? alu_sub : alu_add;
			3'b001:  op = alu_sll;
			3'b010:  op = alu_slt;
			3'b011:  op = alu_sltu;
			3'b100:  op = alu_xor;
			3'b101:  op = alt_bit ? alu_sra : alu_srl;
			3'b110:  op = alu_or;
			default: op = alu_and;
		endcase
	end

	// unknown opcodes are dropped here
	assign issue = inst_valid & ~stall & known_op;

endmodule

`default_nettype wire

// ==== reg_rename.sv ====
`timescale 1ns/1ps
`default_nettype none

module reg_rename import ooo_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         issue,
	input  reg_idx_t                     rs1,
	input  reg_idx_t                     rs2,
	input  reg_idx_t                     rd,
	input  logic [$clog2(rob_depth)-1:0] alloc_tag,
	input  logic [rob_depth-1:0]         rob_ready_mask,
	input  word_t                        rob_values [rob_depth],
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  word_t                        cdb_value,
	input  logic                         commit_valid,
	input  reg_idx_t                     commit_rd,
	input  logic [$clog2(rob_depth)-1:0] commit_tag,
	input  word_t                        commit_data,
	output logic                         src1_ready,
	output logic                         src2_ready,
	output word_t                        src1_value,
	output word_t                        src2_value,
	output logic [$clog2(rob_depth)-1:0] src1_tag,
	output logic [$clog2(rob_depth)-1:0] src2_tag
);

	localparam int tag_w = $clog2(rob_depth);

	// architectural state
	word_t            regs [32];
	logic [31:0]      map_valid;
	logic [tag_w-1:0] map_tag [32];

	// both sources share one lookup loop
	reg_idx_t         src_idx [2];
	logic             src_rdy [2];
	word_t            src_val [2];
	logic [tag_w-1:0] src_tg  [2];

	assign src_idx[0] = rs1;
	assign src_idx[1] = rs2;

	////////////////////////////////
	// source lookup
	////////////////////////////////

	always_comb begin
		for (int s = 0; s < 2; s++) begin
			src_tg[s] = map_tag[src_idx[s]];
			if (!map_valid[src_idx[s]]) begin
				// not renamed, file holds the value
				src_rdy[s] = 1'b1;
				src_val[s] = regs[src_idx[s]];
			end else if (rob_ready_mask[src_tg[s]]) begin
				src_rdy[s] = 1'b1;
				src_val[s] = rob_values[src_tg[s]];
			end else if (cdb_valid && cdb_tag == src_tg[s]) begin
				// result on the bus right now
				src_rdy[s] = 1'b1;
				src_val[s] = cdb_value;
			end else begin
				src_rdy[s] = 1'b0;
				src_val[s] = '0;
			end
		end
	end

	assign src1_ready = src_rdy[0];
	assign src2_ready = src_rdy[1];
	assign src1_value = src_val[0];
	assign src2_value = src_val[1];
	assign src1_tag   = src_tg[0];
	assign src2_tag   = src_tg[1];

	////////////////////////////////
	// commit write and map update
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			map_valid <= '0;
			for (int r = 0; r < 32; r++) begin
				regs[r] <= '0;
			end
		end else begin
			if (commit_valid && commit_rd != '0) begin
				regs[commit_rd] <= commit_data;
				// only drop the mapping if no younger writer took it
				if (map_valid[commit_rd] && map_tag[commit_rd] == commit_tag) begin
					map_valid[commit_rd] <= 1'b0;
				end
			end
			// newest writer wins over the commit clear
			if (issue && rd != '0) begin
				map_valid[rd] <= 1'b1;
				map_tag[rd]   <= alloc_tag;
			end
		end
	end

endmodule

`default_nettype wire

// ==== reservation_station.sv ====
`timescale 1ns/1ps
`default_nettype none

module reservation_station import ooo_pkg::*; #(
	parameter int rs_depth  = 4,
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         issue,
	input  alu_op_e                      op,
	input  logic                         use_imm,
	input  word_t                        imm,
	input  logic [$clog2(rob_depth)-1:0] alloc_tag,
	input  logic                         src1_ready,
	input  logic                         src2_ready,
	input  word_t                        src1_value,
	input  word_t                        src2_value,
	input  logic [$clog2(rob_depth)-1:0] src1_tag,
	input  logic [$clog2(rob_depth)-1:0] src2_tag,
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  word_t                        cdb_value,
	output logic                         rs_full,
	output logic                         dispatch,
	output alu_op_e                      dispatch_op,
	output word_t                        dispatch_a,
	output word_t                        dispatch_b,
	output logic [$clog2(rob_depth)-1:0] dispatch_tag
);

	localparam int tag_w = $clog2(rob_depth);
	localparam int idx_w = (rs_depth > 1) ? $clog2(rs_depth) : 1;

	// entry storage
	logic [rs_depth-1:0] valid_q;
	alu_op_e             op_q    [rs_depth];
	logic [tag_w-1:0]    dest_q  [rs_depth];
	logic                a_rdy_q [rs_depth];
	word_t               a_val_q [rs_depth];
	logic [tag_w-1:0]    a_tag_q [rs_depth];
	logic                b_rdy_q [rs_depth];
	word_t               b_val_q [rs_depth];
	logic [tag_w-1:0]    b_tag_q [rs_depth];

	logic [idx_w-1:0] free_idx;
	logic [idx_w-1:0] disp_idx;

	assign rs_full = &valid_q;

	////////////////////////////////
	// free slot and ready pick
	////////////////////////////////

	// walk down so the lowest index wins
	always_comb begin
		free_idx = '0;
		disp_idx = '0;
		dispatch = 1'b0;
		for (int e = rs_depth - 1; e >= 0; e--) begin
			if (!valid_q[e]) begin
				free_idx = idx_w'(e);
			end
			if (valid_q[e] && a_rdy_q[e] && b_rdy_q[e]) begin
				disp_idx = idx_w'(e);
				dispatch = 1'b1;
			end
		end
	end

	assign dispatch_op  = op_q[disp_idx];
	assign dispatch_a   = a_val_q[disp_idx];
	assign dispatch_b   = b_val_q[disp_idx];
	assign dispatch_tag = dest_q[disp_idx];

	////////////////////////////////
	// write, wakeup, free
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q <= '0;
		end else begin
			// snoop the result bus for waiting operands
			for (int e = 0; e < rs_depth; e++) begin
				if (valid_q[e] && cdb_valid) begin
					if (!a_rdy_q[e] && a_tag_q[e] == cdb_tag) begin
						a_rdy_q[e] <= 1'b1;
						a_val_q[e] <= cdb_value;
					end
					if (!b_rdy_q[e] && b_tag_q[e] == cdb_tag) begin
						b_rdy_q[e] <= 1'b1;
						b_val_q[e] <= cdb_value;
					end
				end
			end
			if (dispatch) begin
				valid_q[disp_idx] <= 1'b0;
			end
			// issue only comes when a slot is free
			if (issue) begin
				valid_q[free_idx] <= 1'b1;
				op_q[free_idx]    <= op;
				dest_q[free_idx]  <= alloc_tag;
				a_rdy_q[free_idx] <= src1_ready;
				a_val_q[free_idx] <= src1_value;
				a_tag_q[free_idx] <= src1_tag;
				// immediate is a second operand that is already there
				b_rdy_q[free_idx] <= use_imm | src2_ready;
				b_val_q[free_idx] <= use_imm ? imm : src2_value;
				b_tag_q[free_idx] <= src2_tag;
			end
		end
	end

endmodule

`default_nettype wire

// ==== alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit import ooo_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         dispatch,
	input  alu_op_e                      dispatch_op,
	input  word_t                        dispatch_a,
	input  word_t                        dispatch_b,
	input  logic [$clog2(rob_depth)-1:0] dispatch_tag,
	output logic                         cdb_valid,
	output logic [$clog2(rob_depth)-1:0] cdb_tag,
	output word_t                        cdb_value
);

	word_t      result;
	logic [4:0] shamt;

	// shifts take only the low five bits
	assign shamt = dispatch_b[4:0];

	always_comb begin
		case (dispatch_op)
			alu_add:  result = dispatch_a + dispatch_b;
			alu_sub:  result = dispatch_a - dispatch_b;
			alu_sll:  result = dispatch_a << shamt;
			alu_slt:  result = word_t'($signed(dispatch_a) < $signed(dispatch_b));
			alu_sltu: result = word_t'(dispatch_a < dispatch_b);
			alu_xor:  result = dispatch_a ^ dispatch_b;
			alu_srl:  result = dispatch_a >> shamt;
			alu_sra:  result = word_t'($signed(dispatch_a) >>> shamt);
			alu_or:   result = dispatch_a | dispatch_b;
			default:  result = dispatch_a & dispatch_b;
		endcase
	end

	// one result per cycle onto the bus
	always_ff @(posedge clock) begin
		if (reset) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= dispatch;
		end
		cdb_tag   <= dispatch_tag;
		cdb_value <= result;
	end

endmodule

`default_nettype wire

// ==== reorder_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer import ooo_pkg::*; #(
	parameter int rob_depth = 8
) (
	input  logic                         clock,
	input  logic                         reset,
	input  logic                         issue,
	input  reg_idx_t                     rd,
	input  logic                         cdb_valid,
	input  logic [$clog2(rob_depth)-1:0] cdb_tag,
	input  word_t                        cdb_value,
	output logic                         rob_full,
	output logic [$clog2(rob_depth)-1:0] alloc_tag,
	output logic [rob_depth-1:0]         rob_ready_mask,
	output word_t                        rob_values [rob_depth],
	output logic                         commit_valid,
	output reg_idx_t                     commit_rd,
	output logic [$clog2(rob_depth)-1:0] commit_tag,
	output word_t                        commit_data
);

	localparam int tag_w = $clog2(rob_depth);

	// pointers wrap on their own, depth is a power of two
	logic [tag_w-1:0] head_q;
	logic [tag_w-1:0] tail_q;
	logic [tag_w:0]   count_q;

	// entry contents
	logic [rob_depth-1:0] ready_q;
	reg_idx_t             rd_q    [rob_depth];
	word_t                value_q [rob_depth];

	assign rob_full       = (count_q == (tag_w+1)'(rob_depth));
	assign alloc_tag      = tail_q;
	assign rob_ready_mask = ready_q;
	assign rob_values     = value_q;

	////////////////////////////////
	// head retire
	////////////////////////////////

	assign commit_valid = (count_q != '0) & ready_q[head_q];
	assign commit_rd    = rd_q[head_q];
	assign commit_tag   = head_q;
	assign commit_data  = value_q[head_q];

	////////////////////////////////
	// pointers and count
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q  <= '0;
			tail_q  <= '0;
			count_q <= '0;
		end else begin
			if (issue) begin
				tail_q <= tail_q + 1'b1;
			end
			if (commit_valid) begin
				head_q <= head_q + 1'b1;
			end
			case ({issue, commit_valid})
				2'b10:   count_q <= count_q + 1'b1;
				2'b01:   count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	////////////////////////////////
	// entry state
	////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			ready_q <= '0;
		end else begin
			if (commit_valid) begin
				ready_q[head_q] <= 1'b0;
			end
			// result lands and is ready from the next cycle
			if (cdb_valid) begin
				ready_q[cdb_tag] <= 1'b1;
			end
			if (issue) begin
				ready_q[tail_q] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (cdb_valid) begin
			value_q[cdb_tag] <= cdb_value;
		end
		if (issue) begin
			rd_q[tail_q] <= rd;
		end
	end

endmodule

`default_nettype wire

// ==== ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module ooo_core import ooo_pkg::*; #(
	parameter int rob_depth = 8,
	parameter int rs_depth  = 4
) (
	input  logic       clock,
	input  logic       reset,
	input  logic       inst_valid,
	input  inst_word_u inst,
	output logic       stall,
	output logic       commit_valid,
	output reg_idx_t   commit_rd,
	output word_t      commit_data
);

	localparam int tag_w = $clog2(rob_depth);

	// decode outputs
	logic     issue;
	alu_op_e  op;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	logic     use_imm;
	word_t    imm;

	// rob side
	logic                 rob_full;
	logic [tag_w-1:0]     alloc_tag;
	logic [rob_depth-1:0] rob_ready_mask;
	word_t                rob_values [rob_depth];
	logic [tag_w-1:0]     commit_tag;

	// renamed sources
	logic             src1_ready;
	logic             src2_ready;
	word_t            src1_value;
	word_t            src2_value;
	logic [tag_w-1:0] src1_tag;
	logic [tag_w-1:0] src2_tag;

	// station to alu
	logic             rs_full;
	logic             dispatch;
	alu_op_e          dispatch_op;
	word_t            dispatch_a;
	word_t            dispatch_b;
	logic [tag_w-1:0] dispatch_tag;

	// result bus
	logic             cdb_valid;
	logic [tag_w-1:0] cdb_tag;
	word_t            cdb_value;

	////////////////////////////////
	// decode
	////////////////////////////////

	issue_decode u_decode (
		.inst_valid (inst_valid),
		.inst       (inst),
		.rob_full   (rob_full),
		.rs_full    (rs_full),
		.stall      (stall),
		.issue      (issue),
		.op         (op),
		.rd         (rd),
		.rs1        (rs1),
		.rs2        (rs2),
		.use_imm    (use_imm),
		.imm        (imm)
	);

	reg_rename #(
		.rob_depth (rob_depth)
	) u_rename (
		.clock          (clock),
		.reset          (reset),
		.issue          (issue),
		.rs1            (rs1),
		.rs2            (rs2),
		.rd             (rd),
		.alloc_tag      (alloc_tag),
		.rob_ready_mask (rob_ready_mask),
		.rob_values     (rob_values),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_value      (cdb_value),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_tag     (commit_tag),
		.commit_data    (commit_data),
		.src1_ready     (src1_ready),
		.src2_ready     (src2_ready),
		.src1_value     (src1_value),
		.src2_value     (src2_value),
		.src1_tag       (src1_tag),
		.src2_tag       (src2_tag)
	);

	////////////////////////////////
	// execute
	////////////////////////////////

	reservation_station #(
		.rs_depth  (rs_depth),
		.rob_depth (rob_depth)
	) u_station (
		.clock        (clock),
		.reset        (reset),
		.issue        (issue),
		.op           (op),
		.use_imm      (use_imm),
		.imm          (imm),
		.alloc_tag    (alloc_tag),
		.src1_ready   (src1_ready),
		.src2_ready   (src2_ready),
		.src1_value   (src1_value),
		.src2_value   (src2_value),
		.src1_tag     (src1_tag),
		.src2_tag     (src2_tag),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_value    (cdb_value),
		.rs_full      (rs_full),
		.dispatch     (dispatch),
		.dispatch_op  (dispatch_op),
		.dispatch_a   (dispatch_a),
		.dispatch_b   (dispatch_b),
		.dispatch_tag (dispatch_tag)
	);

	alu_unit #(
		.rob_depth (rob_depth)
	) u_alu (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.dispatch_op  (dispatch_op),
		.dispatch_a   (dispatch_a),
		.dispatch_b   (dispatch_b),
		.dispatch_tag (dispatch_tag),
		.cdb_valid    (cdb_valid),
		.cdb_tag      (cdb_tag),
		.cdb_value    (cdb_value)
	);

	////////////////////////////////
	// result and commit
	////////////////////////////////

	reorder_buffer #(
		.rob_depth (rob_depth)
	) u_rob (
		.clock          (clock),
		.reset          (reset),
		.issue          (issue),
		.rd             (rd),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_value      (cdb_value),
		.rob_full       (rob_full),
		.alloc_tag      (alloc_tag),
		.rob_ready_mask (rob_ready_mask),
		.rob_values     (rob_values),
		.commit_valid   (commit_valid),
		.commit_rd      (commit_rd),
		.commit_tag     (commit_tag),
		.commit_data    (commit_data)
	);

endmodule

`default_nettype wire

// ==== tb_ooo_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ooo_core import ooo_pkg::*; ();

	localparam int rob_depth  = 8;
	localparam int rs_depth   = 4;
	localparam int clk_period = 10;
	// upper bound on instructions offered across all tests
	localparam int planned_insts = 80;
	localparam int margin_cycles = 200;
	localparam int watchdog_ns   = (planned_insts * rob_depth * 10 + margin_cycles) * clk_period;

	logic       clock;
	logic       reset;
	logic       inst_valid;
	inst_word_u inst;
	logic       stall;
	logic       commit_valid;
	reg_idx_t   commit_rd;
	word_t      commit_data;

	// reference model state
	word_t    model_regs [32];
	reg_idx_t exp_rd_q [$];
	word_t    exp_val_q [$];
	int       issued_count;
	int       commit_count;
	int       value_errors;
	int       other_errors;
	logic     seen_stall;

	ooo_core #(
		.rob_depth (rob_depth),
		.rs_depth  (rs_depth)
	) UUT (
		.clock        (clock),
		.reset        (reset),
		.inst_valid   (inst_valid),
		.inst         (inst),
		.stall        (stall),
		.commit_valid (commit_valid),
		.commit_rd    (commit_rd),
		.commit_data  (commit_data)
	);

	initial begin
		clock = 1'b0;
		forever #(clk_period / 2) clock = ~clock;
	end

	//////////////////////////////
	// compare tasks
	//////////////////////////////

	task automatic check_reg(reg_idx_t got, reg_idx_t exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is x%0d, expected x%0d", $time, what, got, exp);
		end
	endtask

	task automatic check_word(word_t got, word_t exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_level(logic got, logic exp, string what);
		if (got !== exp) begin
			value_errors++;
			$display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	//////////////////////////////
	// reference model
	//////////////////////////////

	// rv32i alu semantics
	function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
		logic [63:0] wide;
		logic [4:0]  sh;
		word_t       flip;
		sh   = b[4:0];
		flip = 32'h8000_0000;
		// sign fill for arithmetic shift
		wide = {{32{a[31]}}, a} >> sh;
		case (op)
			alu_add:  return a + b;
			alu_sub:  return a - b;
			alu_sll:  return a << sh;
			// signed compare by biasing the sign bit
			alu_slt:  return word_t'((a ^ flip) < (b ^ flip));
			alu_sltu: return word_t'(a < b);
			alu_xor:  return a ^ b;
			alu_srl:  return a >> sh;
			alu_sra:  return wide[31:0];
			alu_or:   return a | b;
			default:  return a & b;
		endcase
	endfunction

	function automatic logic [2:0] funct3_of(alu_op_e op);
		case (op)
			alu_add, alu_sub: return 3'b000;
			alu_sll:          return 3'b001;
			alu_slt:          return 3'b010;
			alu_sltu:         return 3'b011;
			alu_xor:          return 3'b100;
			alu_srl, alu_sra: return 3'b101;
			alu_or:           return 3'b110;
			default:          return 3'b111;
		endcase
	endfunction

	function automatic inst_word_u make_r_inst(alu_op_e op, reg_idx_t rd, reg_idx_t rs1,
			reg_idx_t rs2);
		inst_word_u w;
		w.r.opcode = opcode_op;
		w.r.rd     = rd;
		w.r.rs1    = rs1;
		w.r.rs2    = rs2;
		w.r.funct3 = funct3_of(op);
		w.r.funct7 = (op == alu_sub || op == alu_sra) ? 7'b0100000 : 7'b0000000;
		return w;
	endfunction

	function automatic inst_word_u make_i_inst(alu_op_e op, reg_idx_t rd, reg_idx_t rs1,
			logic [11:0] imm12);
		inst_word_u w;
		w.i.opcode = opcode_op_imm;
		w.i.rd     = rd;
		w.i.rs1    = rs1;
		w.i.funct3 = funct3_of(op);
		w.i.imm12  = imm12;
		return w;
	endfunction

	//////////////////////////////
	// drivers
	//////////////////////////////

	// hold the word until a falling edge sees stall low
	task automatic offer_inst(inst_word_u w);
		@(negedge clock);
		inst       = w;
		inst_valid = 1'b1;
		while (stall) begin
			seen_stall = 1'b1;
			@(negedge clock);
		end
	endtask

	task automatic push_expected(reg_idx_t rd, word_t value);
		exp_rd_q.push_back(rd);
		exp_val_q.push_back(value);
		issued_count++;
		// x0 keeps zero, commit still reports the value
		if (rd != 0) begin
			model_regs[rd] = value;
		end
	endtask

	task automatic issue_r(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
		word_t value;
		value = model_alu(op, model_regs[rs1], model_regs[rs2]);
		offer_inst(make_r_inst(op, rd, rs1, rs2));
		push_expected(rd, value);
	endtask

	task automatic issue_i(alu_op_e op, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm12);
		logic [11:0] field;
		word_t       value;
		field = imm12;
		// shift forms carry funct7 in the upper immediate bits
		if (op == alu_sll || op == alu_srl || op == alu_sra) begin
			field = {(op == alu_sra) ? 7'b0100000 : 7'b0000000, imm12[4:0]};
		end
		value = model_alu(op, model_regs[rs1], {{20{field[11]}}, field});
		offer_inst(make_i_inst(op, rd, rs1, field));
		push_expected(rd, value);
	endtask

	// foreign opcode, nothing expected back
	task automatic issue_raw(logic [31:0] bits);
		offer_inst(inst_word_u'(bits));
	endtask

	task automatic go_idle();
		@(negedge clock);
		inst_valid = 1'b0;
		inst       = '0;
	endtask

	task automatic wait_drain();
		while (exp_rd_q.size() != 0) begin
			@(negedge clock);
		end
	endtask

	// pseudo-random word from three instructions
	task automatic load_random(reg_idx_t rd);
		issue_i(alu_add, rd, 0, 12'($urandom));
		issue_i(alu_sll, rd, rd, 12'd20);
		issue_i(alu_xor, rd, rd, 12'($urandom));
	endtask

	//////////////////////////////
	// commit monitor
	//////////////////////////////

	always @(negedge clock) begin
		if (!reset && commit_valid) begin
			commit_count++;
			if (exp_rd_q.size() == 0) begin
				other_errors++;
				$display("commit of x%0d at %0t ns with no instruction left to commit",
					commit_rd, $time);
			end else begin
				check_reg(commit_rd, exp_rd_q.pop_front(), "commit rd");
				check_word(commit_data, exp_val_q.pop_front(), "commit data");
			end
		end
	end

	//////////////////////////////
	// directed tests
	//////////////////////////////

	task automatic reset_quiet();
		repeat (5) begin
			@(negedge clock);
			check_level(stall, 1'b0, "stall after reset");
			check_level(commit_valid, 1'b0, "commit_valid after reset");
		end
	endtask

	task automatic r_type_ops();
		alu_op_e all_ops [10];
		all_ops = '{alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
			alu_xor, alu_srl, alu_sra, alu_or, alu_and};
		load_random(1);
		load_random(2);
		for (int k = 0; k < 10; k++) begin
			issue_r(all_ops[k], reg_idx_t'(10 + k), 1, 2);
		end
		go_idle();
		wait_drain();
	endtask

	task automatic i_type_ops();
		// x6 = -1234
		issue_i(alu_add, 6, 0, 12'hb2e);
		issue_i(alu_add, 7, 6, 12'hffb);
		issue_i(alu_slt, 8, 6, 12'hf9c);
		issue_i(alu_sltu, 9, 6, 12'hfff);
		issue_i(alu_slt, 10, 6, 12'h005);
		issue_i(alu_sll, 11, 6, 12'd3);
		issue_i(alu_srl, 12, 6, 12'd7);
		issue_i(alu_sra, 13, 6, 12'd7);
		issue_i(alu_xor, 14, 6, 12'hfff);
		issue_i(alu_or, 15, 6, 12'h0f0);
		issue_i(alu_and, 16, 6, 12'hf00);
		go_idle();
		wait_drain();
	endtask

	task automatic dependency_chains();
		issue_i(alu_add, 5, 0, 12'h007);
		// same rd back to back
		issue_r(alu_add, 5, 5, 5);
		issue_r(alu_add, 5, 5, 5);
		issue_r(alu_sub, 5, 5, 1);
		// write to x0, then read it
		issue_i(alu_add, 0, 5, 12'h003);
		issue_r(alu_add, 20, 0, 5);
		issue_r(alu_or, 21, 0, 0);
		issue_r(alu_sll, 22, 5, 5);
		issue_r(alu_sltu, 24, 0, 5);
		go_idle();
		wait_drain();
	endtask

	task automatic stall_burst();
		seen_stall = 1'b0;
		issue_i(alu_add, 23, 0, 12'h001);
		repeat (2 * rob_depth + 4) begin
			issue_i(alu_add, 23, 23, 12'h003);
		end
		issue_r(alu_xor, 25, 23, 1);
		go_idle();
		check_level(seen_stall, 1'b1, "stall during burst");
		wait_drain();
	endtask

	task automatic foreign_opcodes();
		issue_raw(32'h00a2_8063);
		issue_i(alu_add, 26, 0, 12'h055);
		issue_raw(32'h0002_a303);
		issue_raw(32'h1234_5537);
		issue_r(alu_add, 27, 26, 26);
		issue_raw(32'h0000_006f);
		issue_i(alu_xor, 28, 27, 12'hfff);
		go_idle();
		wait_drain();
	endtask

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		reset        = 1'b1;
		inst_valid   = 1'b0;
		inst         = '0;
		issued_count = 0;
		commit_count = 0;
		value_errors = 0;
		other_errors = 0;
		seen_stall   = 1'b0;
		void'($urandom(32'hfd80_54a5));
		for (int r = 0; r < 32; r++) begin
			model_regs[r] = '0;
		end
		repeat (10) @(negedge clock);
		reset = 1'b0;

		reset_quiet();
		r_type_ops();
		i_type_ops();
		dependency_chains();
		stall_burst();
		foreign_opcodes();

		// catch stray commits after the last one
		repeat (10) @(negedge clock);
		if (commit_count != issued_count) begin
			other_errors++;
			$display("%0d instructions issued but %0d commits seen", issued_count,
				commit_count);
		end
		$display("checks done: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("the run timed out after %0d ns without finishing the tests", watchdog_ns);
		$display(">>> FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb.f ====
ooo_pkg.sv
issue_decode.sv
reg_rename.sv
reservation_station.sv
alu_unit.sv
reorder_buffer.sv
ooo_core.sv
tb_ooo_core.sv

// ==== Bender.yml ====
package:
  name: ooo_core

sources:
  - ooo_pkg.sv
  - issue_decode.sv
  - reg_rename.sv
  - reservation_station.sv
  - alu_unit.sv
  - reorder_buffer.sv
  - ooo_core.sv
  - target: simulation
    files:
      - tb_ooo_core.sv
